/* Makefile */
SRCS := $(wildcard hw/*.sv) bench/tb_doc5503.sv

.PHONY: run clean

obj_dir/Vtb_doc5503: all.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_doc5503 -f all.f

run: obj_dir/Vtb_doc5503
	@out="$$(./obj_dir/Vtb_doc5503)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

/* all.f */
hw/doc_pkg.sv
hw/osc_regs_if.sv
hw/mix_if.sv
hw/osc_register_file.sv
hw/wave_address_gen.sv
hw/osc_sequencer.sv
hw/voice_mixer.sv
hw/doc5503_top.sv
bench/tb_doc5503.sv

/* bench/tb_doc5503.sv */
// wavetable engine testbench
`timescale 1ns/10ps

module tb_doc5503;

    logic clk_i = 1'b0;
    logic reset_n_i;
    logic clk_en_i;
    logic cs_n_i;
    logic we_n_i;
    logic [7:0] addr_i;
    logic [7:0] data_i;
    logic [7:0] data_o;
    logic [15:0] wave_address_o;
    logic wave_rd_o;
    logic wave_data_ready_i;
    logic [7:0] wave_data_i;
    logic signed [15:0] mono_mix_o;

    // 64 KB wave memory and its two-stage answer pipeline
    logic [7:0] wave_mem [65536];
    logic pipe_vld [2];
    logic [15:0] pipe_addr [2];

    integer seed = 33;
    int checks = 0;
    int errors = 0;
    int timeouts = 0;
    int en_cnt = 0;

    // reference model of one oscillator that runs while track_on is set
    logic track_on = 1'b0;
    logic [23:0] exp_acc;
    logic [15:0] cur_freq;
    logic [7:0] cur_res;
    logic [7:0] cur_ptr;
    int page_reads [256];

    doc5503_top u_dut (.*);

    always #4 clk_i = ~clk_i;

    // one enable pulse in every eight clocks
    always @(negedge clk_i) begin
        en_cnt = (en_cnt + 1) % 8;
        clk_en_i = (en_cnt == 7);
    end

    // the memory answers two clocks after wave_rd_o is seen
    always @(negedge clk_i) begin
        pipe_vld[1] = pipe_vld[0];
        pipe_addr[1] = pipe_addr[0];
        pipe_vld[0] = wave_rd_o;
        pipe_addr[0] = wave_address_o;
        wave_data_ready_i = pipe_vld[1];
        wave_data_i = pipe_vld[1] ? wave_mem[pipe_addr[1]] : 8'h00;
    end

    // expected wave address with the overflow flag in bit 16
    function automatic logic [16:0] ref_address(input logic [23:0] acc,
                                                input logic [7:0] rs,
                                                input logic [7:0] ptr);
        int sh;
        int size;
        logic [15:0] off;
        logic ovf;
        logic [7:0] page;
        size = int'(rs[5:3]);
        sh = 9 + int'(rs[2:0]) - size;
        off = 16'(acc >> sh);
        ovf = off[8 + size];
        // a bigger table leaves fewer pointer bits
        page = ptr & ~8'((9'h001 << size) - 9'h001);
        return {ovf, (ovf ? 16'h0000 : off) | {page, 8'h00}};
    endfunction

    // expected scaled sample of one byte at one volume
    function automatic logic [15:0] ref_sample(input logic [7:0] b, input logic [7:0] v);
        int s;
        int p;
        s = int'(b) - 128;
        p = s * int'(v >> 1);
        return 16'(p >>> 2);
    endfunction

    // compares every read against the model and counts reads per page
    always @(negedge clk_i) begin
        logic [16:0] r;
        if (reset_n_i && wave_rd_o) begin
            page_reads[wave_address_o[15:8]]++;
            if (track_on) begin
                exp_acc = exp_acc + 24'(cur_freq);
                r = ref_address(exp_acc, cur_res, cur_ptr);
                checks++;
                assert (wave_address_o == r[15:0]) else begin
                    $display("FAIL wave_address_o got=%h exp=%h", wave_address_o, r[15:0]);
                    errors++;
                end
                // free run wraps the accumulator back to zero on overflow
                if (r[16]) begin
                    exp_acc = '0;
                end
            end
        end
    end

    task automatic do_reset();
        @(negedge clk_i);
        reset_n_i = 1'b0;
        @(negedge clk_i);
        track_on = 1'b0;
        exp_acc = '0;
        @(negedge clk_i);
        reset_n_i = 1'b1;
        // the clearing sweep needs 32 clocks
        repeat (40) @(negedge clk_i);
    endtask

    task automatic write_reg(input logic [7:0] a, input logic [7:0] d);
        @(negedge clk_i);
        cs_n_i = 1'b0;
        we_n_i = 1'b0;
        addr_i = a;
        data_i = d;
        @(negedge clk_i);
        cs_n_i = 1'b1;
        we_n_i = 1'b1;
    endtask

    task automatic read_reg(input logic [7:0] a, output logic [7:0] d);
        @(negedge clk_i);
        addr_i = a;
        #1 d = data_o;
    endtask

    task automatic check_reg(input logic [7:0] a, input logic [7:0] e);
        logic [7:0] d;
        read_reg(a, d);
        checks++;
        assert (d == e) else begin
            $display("FAIL data_o addr=%h got=%h exp=%h", a, d, e);
            errors++;
        end
    endtask

    // control is written last so the oscillator starts with its settings in place
    task automatic set_osc(input int i, input logic [15:0] f, input logic [7:0] vol,
                           input logic [7:0] ptr, input logic [7:0] rs, input logic [7:0] ctl);
        write_reg(8'h00 + 8'(i), f[7:0]);
        write_reg(8'h20 + 8'(i), f[15:8]);
        write_reg(8'h40 + 8'(i), vol);
        write_reg(8'h80 + 8'(i), ptr);
        write_reg(8'hC0 + 8'(i), rs);
        write_reg(8'hA0 + 8'(i), ctl);
    endtask

    task automatic wait_halt(input int i, input int limit);
        logic [7:0] d;
        int n;
        d = 8'h00;
        for (n = 0; n < limit && !d[0]; n++) begin
            read_reg(8'hA0 + 8'(i), d);
        end
        assert (d[0]) else begin
            $display("timeout: oscillator %0d never halted", i);
            timeouts++;
        end
    endtask

    task automatic wait_mix(input logic [15:0] e, input int limit);
        int n;
        for (n = 0; n < limit && mono_mix_o != e; n++) begin
            @(negedge clk_i);
        end
        checks++;
        assert (mono_mix_o == e) else begin
            $display("FAIL mono_mix_o got=%h exp=%h", mono_mix_o, e);
            errors++;
        end
    endtask

    task automatic check_frame_reads(input int n);
        logic seen [256];
        int reads;
        int distinct;
        int fc;
        reads = 0;
        distinct = 0;
        fc = (n * 8 + 24) * 8;
        for (int p = 0; p < 256; p++) begin
            seen[p] = 1'b0;
        end
        repeat (3 * fc) @(negedge clk_i);
        // one frame window holds exactly one read from each served slot
        repeat (fc) begin
            @(negedge clk_i);
            if (wave_rd_o) begin
                reads++;
                if (!seen[wave_address_o[15:8]]) begin
                    distinct++;
                end
                seen[wave_address_o[15:8]] = 1'b1;
                checks++;
                assert (wave_address_o[15:8] <= 8'(8'h50 + n)) else begin
                    $display("FAIL wave_address_o got=%h exp below page %h",
                             wave_address_o, 8'(8'h51 + n));
                    errors++;
                end
            end
        end
        checks++;
        assert (reads == n + 1 && distinct == n + 1) else begin
            $display("FAIL read count got=%h distinct=%h exp=%h", reads, distinct, n + 1);
            errors++;
        end
    endtask

    initial begin
        logic [7:0] written [256];
        int snap;
        reset_n_i = 1'b0;
        clk_en_i = 1'b0;
        cs_n_i = 1'b1;
        we_n_i = 1'b1;
        addr_i = 8'h00;
        data_i = 8'h00;
        wave_data_ready_i = 1'b0;
        wave_data_i = 8'h00;
        pipe_vld[0] = 1'b0;
        pipe_vld[1] = 1'b0;
        for (int a = 0; a < 65536; a++) begin
            // zero would end a table so random data avoids it
            wave_mem[a] = 8'($random(seed));
            if (wave_mem[a] == 8'h00) begin
                wave_mem[a] = 8'hA5;
            end
        end
        for (int a = 0; a < 256; a++) begin
            wave_mem[16'h4000 + a] = 8'hC0;
            wave_mem[16'h4100 + a] = 8'h30;
            wave_mem[16'h4300 + a] = 8'h55;
            page_reads[a] = 0;
        end
        wave_mem[16'h4310] = 8'h00;

        // sweep results and then random writes with every oscillator kept halted
        do_reset();
        for (int i = 0; i < 32; i++) begin
            check_reg(8'hA0 + 8'(i), 8'h01);
            check_reg(8'h60 + 8'(i), 8'h80);
        end
        for (int a = 0; a < 224; a++) begin
            written[a] = 8'($random(seed));
            if (a[7:5] == 3'd5) begin
                written[a] = written[a] | 8'h01;
            end
            write_reg(8'(a), written[a]);
        end
        written[8'hE1] = 8'($random(seed));
        write_reg(8'hE1, written[8'hE1]);
        for (int a = 0; a < 224; a++) begin
            check_reg(8'(a), written[a]);
        end
        check_reg(8'hE1, written[8'hE1]);
        check_reg(8'hE0, 8'h00);

        // free-run addresses for several table layouts, the first one wrapping its table
        for (int k = 0; k < 3; k++) begin
            do_reset();
            write_reg(8'hE1, 8'h02);
            cur_freq = (k == 0) ? 16'h8000 : (k == 1) ? 16'h1234 : 16'hF000;
            cur_res = (k == 0) ? 8'h00 : (k == 1) ? 8'h1A : 8'h3F;
            cur_ptr = (k == 0) ? 8'h12 : (k == 1) ? 8'h57 : 8'hFF;
            track_on = 1'b1;
            set_osc(0, cur_freq, 8'h80, cur_ptr, cur_res, 8'h00);
            repeat (10 * 256) @(negedge clk_i);
        end

        // constant pages give a known mix
        do_reset();
        write_reg(8'hE1, 8'h02);
        set_osc(0, 16'h0400, 8'hF0, 8'h40, 8'h00, 8'h00);
        set_osc(1, 16'h0200, 8'h64, 8'h41, 8'h00, 8'h00);
        wait_mix(ref_sample(8'hC0, 8'hF0) + ref_sample(8'h30, 8'h64), 3 * 256 + 64);

        // one-shot stops after the table end and falls silent
        do_reset();
        write_reg(8'hE1, 8'h02);
        set_osc(0, 16'h4000, 8'hFF, 8'h42, 8'h00, 8'h02);
        wait_halt(0, 20 * 256);
        #1 snap = page_reads[8'h42];
        repeat (2 * 256) @(negedge clk_i);
        checks++;
        assert (page_reads[8'h42] == snap) else begin
            $display("FAIL page_reads got=%h exp=%h", page_reads[8'h42], snap);
            errors++;
        end
        wait_mix(16'h0000, 3 * 256 + 64);

        // a zero byte halts a free-running oscillator
        do_reset();
        write_reg(8'hE1, 8'h02);
        set_osc(0, 16'h0400, 8'h80, 8'h43, 8'h00, 8'h00);
        wait_halt(0, 20 * 256);
        check_reg(8'h60, 8'h80);

        // the enable register limits the oscillators served per frame
        for (int n = 1; n <= 3; n += 2) begin
            do_reset();
            write_reg(8'hE1, 8'(2 * n));
            for (int i = 0; i < 6; i++) begin
                set_osc(i, 16'h0100, 8'h40, 8'h50 + 8'(i), 8'h00, 8'h00);
            end
            check_frame_reads(n);
        end

        $display("checks: %0d errors: %0d timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* hw/doc5503_top.sv */
// wavetable sound engine top level
`timescale 1ns/10ps

module doc5503_top import doc_pkg::*; (
    input  logic clk_i,
    input  logic reset_n_i,
    input  logic clk_en_i,
    input  logic cs_n_i,
    input  logic we_n_i,
    input  logic [7:0] addr_i,
    input  logic [7:0] data_i,
    output logic [7:0] data_o,
    output logic [WAVE_ADDR_W-1:0] wave_address_o,
    output logic wave_rd_o,
    input  logic wave_data_ready_i,
    input  logic [7:0] wave_data_i,
    output logic signed [SAMPLE_W-1:0] mono_mix_o
);

    // slot registers between the register file and the sequencer
    osc_regs_if regs_bus ();

    // per-slot samples from the sequencer to the mixer
    mix_if mix_bus ();

    osc_register_file u_regs (
        .clk_i(clk_i),
        .reset_n_i(reset_n_i),
        .cs_n_i(cs_n_i),
        .we_n_i(we_n_i),
        .addr_i(addr_i),
        .data_i(data_i),
        .data_o(data_o),
        .regs(regs_bus.regs)
    );

    osc_sequencer u_seq (
        .clk_i(clk_i),
        .reset_n_i(reset_n_i),
        .clk_en_i(clk_en_i),
        .wave_rd_o(wave_rd_o),
        .wave_address_o(wave_address_o),
        .wave_data_ready_i(wave_data_ready_i),
        .wave_data_i(wave_data_i),
        .regs(regs_bus.seq),
        .mix(mix_bus.seq)
    );

    voice_mixer u_mixer (
        .clk_i(clk_i),
        .reset_n_i(reset_n_i),
        .mix(mix_bus.mix),
        .mono_mix_o(mono_mix_o)
    );

endmodule

/* hw/doc_pkg.sv */
// wavetable engine shared definitions
package doc_pkg;

    // oscillator slot count and the width of a slot index
    localparam int NUM_OSC = 32;
    localparam int OSC_IDX_W = 5;

    // datapath widths
    localparam int ACC_W = 24;
    localparam int FREQ_W = 16;
    localparam int WAVE_ADDR_W = 16;
    localparam int SAMPLE_W = 16;

    // clock enable steps per slot and for the longer last slot that also covers memory refresh
    localparam int SLOT_STEPS = 8;
    localparam int LAST_SLOT_STEPS = 24;

    // unsigned wave data uses 0x80 as the zero level and 0x00 as the end marker
    localparam logic [7:0] SILENT_BYTE = 8'h80;

    // enable register holds twice the last served index so the reset value serves all 32
    localparam logic [7:0] OSC_EN_RESET = 8'h3E;
    localparam logic [7:0] ADDR_OSC_EN = 8'hE1;

    // register group taken from host address bits 7:5
    typedef enum logic [2:0] {
        FREQ_LO   = 3'd0,
        FREQ_HI   = 3'd1,
        VOLUME    = 3'd2,
        WAVE_DATA = 3'd3,
        TABLE_PTR = 3'd4,
        CONTROL   = 3'd5,
        RES_SIZE  = 3'd6,
        GLOBAL    = 3'd7
    } reg_group_e;

    // oscillator mode from control bits 2:1
    typedef enum logic [1:0] {
        FREE_RUN = 2'd0,
        ONE_SHOT = 2'd1,
        SYNC_AM  = 2'd2,
        SWAP     = 2'd3
    } osc_mode_e;

    // per-slot sequencer states
    typedef enum logic [2:0] {
        OSC_IDLE  = 3'd0,
        OSC_START = 3'd1,
        OSC_ACC   = 3'd2,
        OSC_ADDR  = 3'd3,
        OSC_READ  = 3'd4,
        OSC_HALT  = 3'd5,
        OSC_OUT   = 3'd6
    } osc_state_e;

endpackage

/* hw/mix_if.sv */
// sequencer to mixer sample bus
`timescale 1ns/10ps

interface mix_if import doc_pkg::*; ();

    // one pulse per served slot with its byte and volume
    logic sample_valid;
    logic [7:0] sample_byte;
    logic [7:0] sample_vol;

    // marks the end of the last slot in a frame
    logic frame_end;

    modport seq (output sample_valid, sample_byte, sample_vol, frame_end);

    modport mix (input sample_valid, sample_byte, sample_vol, frame_end);

endinterface

/* hw/osc_register_file.sv */
// oscillator register file
`timescale 1ns/10ps

module osc_register_file import doc_pkg::*; (
    input  logic clk_i,
    input  logic reset_n_i,
    input  logic cs_n_i,
    input  logic we_n_i,
    input  logic [7:0] addr_i,
    input  logic [7:0] data_i,
    output logic [7:0] data_o,
    osc_regs_if.regs regs
);

    // one byte per oscillator for each register group
    logic [7:0] freq_lo_r   [NUM_OSC];
    logic [7:0] freq_hi_r   [NUM_OSC];
    logic [7:0] volume_r    [NUM_OSC];
    logic [7:0] wave_data_r [NUM_OSC];
    logic [7:0] table_ptr_r [NUM_OSC];
    logic [7:0] control_r   [NUM_OSC];
    logic [7:0] res_size_r  [NUM_OSC];

    logic [7:0] osc_en_r;

    // power-up sweep walks every slot once
    logic ready_r;
    logic [OSC_IDX_W-1:0] init_idx_r;

    reg_group_e host_group;
    logic [OSC_IDX_W-1:0] host_idx;
    logic host_we;

    // the upper three address bits select the group and the lower five the oscillator
    assign host_group = reg_group_e'(addr_i[7:5]);
    assign host_idx = addr_i[OSC_IDX_W-1:0];
    assign host_we = !cs_n_i && !we_n_i;

    // enable register and sweep counter
    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            osc_en_r <= OSC_EN_RESET;
            ready_r <= 1'b0;
            init_idx_r <= '0;
        end else begin
            if (host_we && (addr_i == ADDR_OSC_EN)) begin
                osc_en_r <= data_i;
            end
            // the sweep ends after the last slot has been cleared
            if (!ready_r) begin
                init_idx_r <= init_idx_r + 1'b1;
                if (init_idx_r == OSC_IDX_W'(NUM_OSC - 1)) begin
                    ready_r <= 1'b1;
                end
            end
        end
    end

    // later assignments win on the same entry so the order below is the write priority
    always_ff @(posedge clk_i) begin
        // host writes have the lowest priority
        if (host_we) begin
            case (host_group)
                FREQ_LO:   freq_lo_r[host_idx] <= data_i;
                FREQ_HI:   freq_hi_r[host_idx] <= data_i;
                VOLUME:    volume_r[host_idx] <= data_i;
                WAVE_DATA: wave_data_r[host_idx] <= data_i;
                TABLE_PTR: table_ptr_r[host_idx] <= data_i;
                CONTROL:   control_r[host_idx] <= data_i;
                RES_SIZE:  res_size_r[host_idx] <= data_i;
                // the global group is handled with the enable register
                default: ;
            endcase
        end

        // a fetched byte lands in the oscillator that asked for it
        if (regs.fetch_we) begin
            wave_data_r[regs.fetch_idx] <= regs.fetch_data;
        end
        // halting silences the slot even if a fetch arrives in the same cycle
        if (regs.wds_silence) begin
            wave_data_r[regs.osc_idx] <= SILENT_BYTE;
        end
        if (regs.halt_req) begin
            control_r[regs.osc_idx] <= control_r[regs.osc_idx] | 8'h01;
        end

        // the power-up sweep overrides everything
        if (!ready_r) begin
            control_r[init_idx_r] <= 8'h01;
            wave_data_r[init_idx_r] <= SILENT_BYTE;
        end
    end

    // host readback is a plain mux on the address
    always_comb begin
        case (host_group)
            FREQ_LO:   data_o = freq_lo_r[host_idx];
            FREQ_HI:   data_o = freq_hi_r[host_idx];
            VOLUME:    data_o = volume_r[host_idx];
            WAVE_DATA: data_o = wave_data_r[host_idx];
            TABLE_PTR: data_o = table_ptr_r[host_idx];
            CONTROL:   data_o = control_r[host_idx];
            RES_SIZE:  data_o = res_size_r[host_idx];
            // only the enable register exists in the global group
            default:   data_o = (addr_i == ADDR_OSC_EN) ? osc_en_r : 8'h00;
        endcase
    end

    // registers of the slot being served
    assign regs.freq = {freq_hi_r[regs.osc_idx], freq_lo_r[regs.osc_idx]};
    assign regs.volume = volume_r[regs.osc_idx];
    assign regs.wave_data = wave_data_r[regs.osc_idx];
    assign regs.table_ptr = table_ptr_r[regs.osc_idx];
    assign regs.res_size = res_size_r[regs.osc_idx];
    assign regs.control = control_r[regs.osc_idx];

    // bits 5:1 give the index of the last enabled oscillator
    assign regs.num_osc = osc_en_r[5:1];
    assign regs.ready = ready_r;

endmodule

/* hw/osc_regs_if.sv */
// register file to sequencer bus
`timescale 1ns/10ps

interface osc_regs_if import doc_pkg::*; ();

    // slot currently served by the sequencer
    logic [OSC_IDX_W-1:0] osc_idx;

    // register contents of that slot
    logic [FREQ_W-1:0] freq;
    logic [7:0] volume;
    logic [7:0] wave_data;
    logic [7:0] table_ptr;
    logic [7:0] res_size;
    logic [7:0] control;

    // global state from the register file
    logic [OSC_IDX_W-1:0] num_osc;
    logic ready;

    // sequencer write requests
    logic halt_req;
    logic wds_silence;
    logic fetch_we;
    logic [OSC_IDX_W-1:0] fetch_idx;
    logic [7:0] fetch_data;

    modport regs (
        input  osc_idx, halt_req, wds_silence, fetch_we, fetch_idx, fetch_data,
        output freq, volume, wave_data, table_ptr, res_size, control, num_osc, ready
    );

    modport seq (
        output osc_idx, halt_req, wds_silence, fetch_we, fetch_idx, fetch_data,
        input  freq, volume, wave_data, table_ptr, res_size, control, num_osc, ready
    );

endinterface

/* hw/osc_sequencer.sv */
// oscillator slot sequencer
`timescale 1ns/10ps

module osc_sequencer import doc_pkg::*; (
    input  logic clk_i,
    input  logic reset_n_i,
    input  logic clk_en_i,
    output logic wave_rd_o,
    output logic [WAVE_ADDR_W-1:0] wave_address_o,
    input  logic wave_data_ready_i,
    input  logic [7:0] wave_data_i,
    osc_regs_if.seq regs,
    mix_if.seq mix
);

    logic [OSC_IDX_W-1:0] slot_r;
    logic [4:0] step_r;
    osc_state_e state_r;

    // one accumulator per oscillator
    logic [ACC_W-1:0] acc_r [NUM_OSC];

    // address and overflow captured in OSC_ADDR
    logic [WAVE_ADDR_W-1:0] addr_r;
    logic ovf_r;
    logic [WAVE_ADDR_W-1:0] gen_address;
    logic gen_overflow;

    // slot that issued the outstanding read
    logic [OSC_IDX_W-1:0] req_idx_r;

    logic adv;
    logic last_slot;
    logic last_step;
    osc_mode_e mode;
    logic one_shot;
    logic halted;
    logic zero_byte;
    logic in_acc;
    logic in_addr;
    logic in_read;
    logic in_halt;
    logic in_out;
    logic silent_acc;
    logic stop_osc;
    logic issue_rd;
    logic acc_add;
    logic acc_clr;

    // nothing moves until the power-up sweep is done
    assign adv = regs.ready && clk_en_i;

    // the last enabled slot runs long to leave room for refresh
    assign last_slot = (slot_r == regs.num_osc);
    assign last_step = last_slot ? (step_r == 5'(LAST_SLOT_STEPS - 1))
                                 : (step_r == 5'(SLOT_STEPS - 1));

    // only mode bit 0 is acted on so sync/am runs free and swap runs one-shot
    assign mode = osc_mode_e'(regs.control[2:1]);
    assign one_shot = (mode == ONE_SHOT) || (mode == SWAP);
    assign halted = regs.control[0];
    // a zero byte marks the end of the waveform
    assign zero_byte = (regs.wave_data == 8'h00);

    assign in_acc = adv && (state_r == OSC_ACC);
    assign in_addr = adv && (state_r == OSC_ADDR);
    assign in_read = adv && (state_r == OSC_READ);
    assign in_halt = adv && (state_r == OSC_HALT);
    assign in_out = adv && (state_r == OSC_OUT);
    assign silent_acc = in_acc && halted;

    // a one-shot table overflow or a zero byte stops the oscillator
    assign stop_osc = zero_byte || (ovf_r && one_shot);
    assign issue_rd = in_read && !stop_osc;

    assign acc_add = in_acc && !halted;
    // a halted one-shot oscillator keeps its accumulator at zero
    assign acc_clr = (silent_acc && one_shot) || (in_read && (ovf_r || zero_byte));

    wave_address_gen u_addr_gen (
        .acc_i(acc_r[slot_r]),
        .res_size_i(regs.res_size),
        .table_ptr_i(regs.table_ptr),
        .address_o(gen_address),
        .overflow_o(gen_overflow)
    );

    // counters, state and request pulses
    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            slot_r <= '0;
            step_r <= '0;
            state_r <= OSC_START;
            wave_rd_o <= 1'b0;
            wave_address_o <= '0;
            regs.halt_req <= 1'b0;
            regs.wds_silence <= 1'b0;
            mix.sample_valid <= 1'b0;
            mix.frame_end <= 1'b0;
        end else begin
            wave_rd_o <= issue_rd;
            // the address stays put until the next read
            if (issue_rd) begin
                wave_address_o <= addr_r;
            end
            regs.halt_req <= in_halt;
            regs.wds_silence <= in_halt;
            mix.sample_valid <= in_out || in_halt || silent_acc;
            mix.frame_end <= adv && last_slot && last_step;

            if (adv) begin
                step_r <= last_step ? '0 : step_r + 1'b1;
                if (last_step) begin
                    slot_r <= last_slot ? '0 : slot_r + 1'b1;
                end

                case (state_r)
                    OSC_START: state_r <= OSC_ACC;
                    OSC_ACC:   state_r <= halted ? OSC_IDLE : OSC_ADDR;
                    OSC_ADDR:  state_r <= OSC_READ;
                    OSC_READ:  state_r <= stop_osc ? OSC_HALT : OSC_OUT;
                    OSC_HALT:  state_r <= OSC_IDLE;
                    OSC_OUT:   state_r <= OSC_IDLE;
                    // wait here for the next slot to begin
                    default: begin
                        if (last_step) begin
                            state_r <= OSC_START;
                        end
                    end
                endcase
            end
        end
    end

    // accumulators are cleared by the sweep and then stepped per slot
    always_ff @(posedge clk_i) begin
        if (!regs.ready) begin
            for (int i = 0; i < NUM_OSC; i++) begin
                acc_r[i] <= '0;
            end
        end else if (acc_clr) begin
            acc_r[slot_r] <= '0;
        end else if (acc_add) begin
            acc_r[slot_r] <= acc_r[slot_r] + ACC_W'(regs.freq);
        end
    end

    // address capture, request tag and outgoing sample
    always_ff @(posedge clk_i) begin
        if (in_addr) begin
            addr_r <= gen_address;
            ovf_r <= gen_overflow;
        end
        if (issue_rd) begin
            req_idx_r <= slot_r;
        end
        if (in_out) begin
            mix.sample_byte <= regs.wave_data;
            mix.sample_vol <= regs.volume;
        end else if (in_halt || silent_acc) begin
            mix.sample_byte <= SILENT_BYTE;
            mix.sample_vol <= 8'h00;
        end
    end

    assign regs.osc_idx = slot_r;

    // the answer may come late and still goes to the requesting slot
    assign regs.fetch_we = wave_data_ready_i;
    assign regs.fetch_idx = req_idx_r;
    assign regs.fetch_data = wave_data_i;

endmodule

/* hw/voice_mixer.sv */
// voice scaler and mono mixer
`timescale 1ns/10ps

module voice_mixer import doc_pkg::*; (
    input  logic clk_i,
    input  logic reset_n_i,
    mix_if.mix mix,
    output logic signed [SAMPLE_W-1:0] mono_mix_o
);

    logic signed [8:0] byte_s;
    logic signed [8:0] vol_s;
    logic signed [17:0] product;
    logic signed [SAMPLE_W-1:0] scaled;
    logic signed [SAMPLE_W-1:0] sum_r;

    // flipping bit 7 turns offset binary into two's complement
    assign byte_s = {~mix.sample_byte[7], ~mix.sample_byte[7], mix.sample_byte[6:0]};

    // half the volume keeps the product positive-scaled within 9 bits
    assign vol_s = {2'b00, mix.sample_vol[7:1]};

    // fits a 9x9 hardware multiplier
    assign product = byte_s * vol_s;

    // drop two more bits for headroom in the frame sum
    assign scaled = product[17:2];

    // the frame sum wraps and is published once per frame
    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            sum_r <= '0;
            mono_mix_o <= '0;
        end else if (mix.frame_end) begin
            mono_mix_o <= sum_r;
            sum_r <= '0;
        end else if (mix.sample_valid) begin
            sum_r <= sum_r + scaled;
        end
    end

endmodule

/* hw/wave_address_gen.sv */
// wave memory address generator
`timescale 1ns/10ps

module wave_address_gen import doc_pkg::*; (
    input  logic [ACC_W-1:0] acc_i,
    input  logic [7:0] res_size_i,
    input  logic [7:0] table_ptr_i,
    output logic [WAVE_ADDR_W-1:0] address_o,
    output logic overflow_o
);

    logic [2:0] res;
    logic [2:0] table_size;
    logic [4:0] shift;
    logic [WAVE_ADDR_W-1:0] shifted;
    logic [3:0] high_bit;
    logic [7:0] ptr_mask;
    logic [WAVE_ADDR_W-1:0] page_base;

    // resolution sits in bits 2:0 and table size in bits 5:3
    assign res = res_size_i[2:0];
    assign table_size = res_size_i[5:3];

    // barrel shift picks a 16-bit window of the accumulator
    assign shift = 5'd9 + 5'(res) - 5'(table_size);
    assign shifted = WAVE_ADDR_W'(acc_i >> shift);

    // the bit just above the table is the overflow flag
    // a 32K table lands on bit 15 since 8 plus 7 is 15
    assign high_bit = {1'b1, table_size};
    assign overflow_o = shifted[high_bit];

    // larger tables use fewer pointer bits
    assign ptr_mask = 8'hFF << table_size;
    assign page_base = {table_ptr_i & ptr_mask, 8'h00};

    // an overflowing offset wraps back to the start of the table
    assign address_o = (overflow_o ? '0 : shifted) | page_base;

endmodule
